/* source/timer_defs.svh */
// Timer register map
`ifndef TIMER_DEFS_SVH
`define TIMER_DEFS_SVH

// ************************************************************************
// register byte offsets
// ************************************************************************
`define TIMER_CFG_LO          6'h00
`define TIMER_CFG_HI          6'h04
`define TIMER_VAL_LO          6'h08
`define TIMER_VAL_HI          6'h0C
`define TIMER_CMP_LO          6'h10
`define TIMER_CMP_HI          6'h14
`define TIMER_START_LO        6'h18
`define TIMER_START_HI        6'h1C
`define TIMER_RESET_LO        6'h20
`define TIMER_RESET_HI        6'h24

`define TIMER_ADDR_BITS       6
`define TIMER_DATA_WIDTH      32

// ************************************************************************
// config register fields, bit 3 reserved
// ************************************************************************
`define TIMER_ENABLE_BIT      0
`define TIMER_RESET_BIT       1   // self clearing
`define TIMER_IRQ_BIT         2
`define TIMER_CMP_CLR_BIT     4
`define TIMER_ONE_SHOT_BIT    5
`define TIMER_PRESC_EN_BIT    6
`define TIMER_REF_CLK_EN_BIT  7
`define TIMER_PRESC_LSB       8
`define TIMER_PRESC_MSB       15

`endif

/* source/timer_bus_pkg.sv */
// Timer Wishbone bus types
`default_nettype none

`include "timer_defs.svh"

package timer_bus_pkg;

   typedef logic [`TIMER_ADDR_BITS-1:0]  wb_addr_t;
   typedef logic [`TIMER_DATA_WIDTH-1:0] wb_data_t;

   // master to slave, classic cycle
   typedef struct packed {
      logic                          cyc;
      logic                          stb;
      logic                          we;
      logic [`TIMER_DATA_WIDTH/8-1:0] sel;   // byte lanes, full words only
      wb_addr_t                      adr;
      wb_data_t                      dat;
   } wb_req_t;

   // slave to master
   typedef struct packed {
      logic     ack;
      wb_data_t dat;     // valid while ack is high on reads
   } wb_rsp_t;

endpackage

`default_nettype wire

/* source/timer_cfg_pkg.sv */
// Timer channel types
`default_nettype none

`include "timer_defs.svh"

package timer_cfg_pkg;

   typedef logic [`TIMER_DATA_WIDTH-1:0]                     count_t;
   typedef logic [`TIMER_PRESC_MSB-`TIMER_PRESC_LSB:0]        presc_t;
   typedef logic [`TIMER_DATA_WIDTH-1:0]                     cfg_t;

   // strobes from the register block, each one cycle wide
   typedef struct packed {
      logic   cfg_we;
      logic   cmp_we;
      logic   val_we;
      logic   start;
      logic   clear;     // reset command
      count_t wdata;     // bus write word
   } chan_cmd_t;

   // channel state seen by the read mux
   typedef struct packed {
      cfg_t   cfg;
      count_t cmp;
      count_t value;
   } chan_stat_t;

endpackage

`default_nettype wire

/* source/timer_wb_regs.sv */
// Timer Wishbone register block
`default_nettype none

`include "timer_defs.svh"

module timer_wb_regs (
   input  wire logic                        clk_i,
   input  wire logic                        rst_ni,

   input  wire timer_bus_pkg::wb_req_t      wb_req_i,
   output timer_bus_pkg::wb_rsp_t           wb_rsp_o,

   output timer_cfg_pkg::chan_cmd_t         cmd_lo_o,
   output timer_cfg_pkg::chan_cmd_t         cmd_hi_o,
   input  wire timer_cfg_pkg::chan_stat_t   stat_lo_i,
   input  wire timer_cfg_pkg::chan_stat_t   stat_hi_i
);

   logic                    ack_q;
   logic                    req_new;   // cycle seen but not yet acknowledged
   logic                    wr_en;
   logic                    rd_en;
   timer_bus_pkg::wb_data_t rdata_d;
   timer_bus_pkg::wb_data_t rdata_q;

   // ************************************************************************
   // classic handshake
   // ************************************************************************
   assign req_new = wb_req_i.cyc & wb_req_i.stb & ~ack_q;
   assign wr_en   = req_new & wb_req_i.we;
   assign rd_en   = req_new & ~wb_req_i.we;

   always_ff @(posedge clk_i or negedge rst_ni)
   begin
      if (!rst_ni)
         ack_q <= 1'b0;
      else
         ack_q <= req_new;   // one cycle, then low until the next request
   end

   assign wb_rsp_o = '{ack: ack_q, dat: rdata_q};

   // ************************************************************************
   // write decode
   // ************************************************************************
   always_comb
   begin
      cmd_lo_o       = '0;
      cmd_hi_o       = '0;
      cmd_lo_o.wdata = wb_req_i.dat;
      cmd_hi_o.wdata = wb_req_i.dat;

      // strobes line up with the edge that raises ack
      if (wr_en)
      begin
         case (wb_req_i.adr)
            `TIMER_CFG_LO:   cmd_lo_o.cfg_we = 1'b1;
            `TIMER_CFG_HI:   cmd_hi_o.cfg_we = 1'b1;
            `TIMER_VAL_LO:   cmd_lo_o.val_we = 1'b1;
            `TIMER_VAL_HI:   cmd_hi_o.val_we = 1'b1;
            `TIMER_CMP_LO:   cmd_lo_o.cmp_we = 1'b1;
            `TIMER_CMP_HI:   cmd_hi_o.cmp_we = 1'b1;
            `TIMER_START_LO: cmd_lo_o.start  = 1'b1;
            `TIMER_START_HI: cmd_hi_o.start  = 1'b1;
            `TIMER_RESET_LO: cmd_lo_o.clear  = 1'b1;
            `TIMER_RESET_HI: cmd_hi_o.clear  = 1'b1;
            default:         ;   // unmapped, write dropped
         endcase
      end
   end

   // ************************************************************************
   // read mux
   // ************************************************************************
   always_comb
   begin
      case (wb_req_i.adr)
         `TIMER_CFG_LO: rdata_d = stat_lo_i.cfg;
         `TIMER_CFG_HI: rdata_d = stat_hi_i.cfg;
         `TIMER_VAL_LO: rdata_d = stat_lo_i.value;
         `TIMER_VAL_HI: rdata_d = stat_hi_i.value;
         `TIMER_CMP_LO: rdata_d = stat_lo_i.cmp;
         `TIMER_CMP_HI: rdata_d = stat_hi_i.cmp;
         default:       rdata_d = '0;   // command offsets and holes
      endcase
   end

   // sampled together with ack going high
   always_ff @(posedge clk_i)
   begin
      if (rd_en)
         rdata_q <= rdata_d;
   end

   // the master keeps its request up until the acknowledge is seen
   ack_with_request_a : assert property (
      @(posedge clk_i) disable iff (!rst_ni)
      ack_q |-> (wb_req_i.cyc && wb_req_i.stb)
   );

endmodule

`default_nettype wire

/* source/timer_channel.sv */
// Timer channel
`default_nettype none

`include "timer_defs.svh"

module timer_channel (
   input  wire logic                        clk_i,
   input  wire logic                        rst_ni,

   input  wire timer_cfg_pkg::chan_cmd_t    cmd_i,
   input  wire logic                        ref_tick_i,   // synced ref_clk edge

   output timer_cfg_pkg::chan_stat_t        stat_o,
   output logic                             irq_o,
   output logic                             busy_o
);

   timer_cfg_pkg::cfg_t   cfg_q;
   timer_cfg_pkg::cfg_t   cfg_d;
   timer_cfg_pkg::count_t cmp_q;
   timer_cfg_pkg::count_t value_q;
   timer_cfg_pkg::count_t value_d;
   timer_cfg_pkg::presc_t presc_q;
   timer_cfg_pkg::presc_t presc_d;
   timer_cfg_pkg::presc_t presc_val;

   logic cnt_reset;    // command or config reset bit
   logic tick;         // selected time base while enabled
   logic presc_hit;
   logic count_tick;
   logic match;

   // ************************************************************************
   // tick source and prescaler
   // ************************************************************************
   assign presc_val = cfg_q[`TIMER_PRESC_MSB:`TIMER_PRESC_LSB];
   assign cnt_reset = cmd_i.clear | cfg_q[`TIMER_RESET_BIT];

   assign tick = cfg_q[`TIMER_ENABLE_BIT] &
                 (cfg_q[`TIMER_REF_CLK_EN_BIT] ? ref_tick_i : 1'b1);

   assign presc_hit  = (presc_q == presc_val);   // every P+1 ticks
   assign count_tick = tick & ~cnt_reset & (~cfg_q[`TIMER_PRESC_EN_BIT] | presc_hit);

   always_comb
   begin
      presc_d = presc_q;
      if (cnt_reset)
         presc_d = '0;
      else if (tick && cfg_q[`TIMER_PRESC_EN_BIT])
         presc_d = presc_hit ? '0 : presc_q + 1'b1;
   end

   // ************************************************************************
   // counter and compare
   // ************************************************************************
   assign match = count_tick & (value_q == cmp_q);

   always_comb
   begin
      value_d = value_q;
      if (cnt_reset)
         value_d = '0;
      else if (cmd_i.val_we)
         value_d = cmd_i.wdata;
      else if (count_tick)
      begin
         if (match && cfg_q[`TIMER_CMP_CLR_BIT])
            value_d = '0;
         else
            value_d = value_q + 1'b1;
      end
   end

   // config word, start wins over the one-shot stop
   always_comb
   begin
      cfg_d = cfg_q;
      if (cmd_i.cfg_we)
         cfg_d = cmd_i.wdata;
      else if (cfg_q[`TIMER_RESET_BIT])
         cfg_d[`TIMER_RESET_BIT] = 1'b0;

      if (cmd_i.start)
         cfg_d[`TIMER_ENABLE_BIT] = 1'b1;
      else if (match && cfg_q[`TIMER_ONE_SHOT_BIT])
         cfg_d[`TIMER_ENABLE_BIT] = 1'b0;
   end

   always_ff @(posedge clk_i or negedge rst_ni)
   begin
      if (!rst_ni)
      begin
         cfg_q   <= '0;
         cmp_q   <= '0;
         value_q <= '0;
         presc_q <= '0;
      end
      else
      begin
         cfg_q   <= cfg_d;
         value_q <= value_d;
         presc_q <= presc_d;
         if (cmd_i.cmp_we)
            cmp_q <= cmd_i.wdata;
      end
   end

   // ************************************************************************
   // outputs
   // ************************************************************************
   assign irq_o  = match & cfg_q[`TIMER_IRQ_BIT];   // one pulse per match
   assign busy_o = cfg_q[`TIMER_ENABLE_BIT];
   assign stat_o = '{cfg: cfg_q, cmp: cmp_q, value: value_q};

   // an irq match moves the counter to zero or just past the compare value
   irq_match_update_a : assert property (
      @(posedge clk_i) disable iff (!rst_ni)
      (irq_o && !cmd_i.val_we)
         |=> (stat_o.value == ($past(cfg_q[`TIMER_CMP_CLR_BIT]) ? '0 : $past(cmp_q) + 1'b1))
   );

   // one-shot match stops the channel unless software restarts it
   one_shot_stop_a : assert property (
      @(posedge clk_i) disable iff (!rst_ni)
      (match && cfg_q[`TIMER_ONE_SHOT_BIT] && !cmd_i.cfg_we && !cmd_i.start)
         |=> !busy_o
   );

endmodule

`default_nettype wire

/* source/timer_unit.sv */
// Two channel timer unit
`default_nettype none

module timer_unit (
   input  wire logic                     clk_i,
   input  wire logic                     rst_ni,
   input  wire logic                     ref_clk_i,

   input  wire timer_bus_pkg::wb_req_t   wb_req_i,
   output timer_bus_pkg::wb_rsp_t        wb_rsp_o,

   output logic                          irq_lo_o,
   output logic                          irq_hi_o,
   output logic                          busy_o
);

   logic ref_meta_q;    // first synchronizer stage
   logic ref_sync_q;
   logic ref_prev_q;    // edge detect
   logic ref_tick;
   logic busy_lo;
   logic busy_hi;

   timer_cfg_pkg::chan_cmd_t  cmd_lo;
   timer_cfg_pkg::chan_cmd_t  cmd_hi;
   timer_cfg_pkg::chan_stat_t stat_lo;
   timer_cfg_pkg::chan_stat_t stat_hi;

   // ************************************************************************
   // ref clock synchronizer and rising edge
   // ************************************************************************
   always_ff @(posedge clk_i or negedge rst_ni)
   begin
      if (!rst_ni)
      begin
         ref_meta_q <= 1'b0;
         ref_sync_q <= 1'b0;
         ref_prev_q <= 1'b0;
      end
      else
      begin
         ref_meta_q <= ref_clk_i;
         ref_sync_q <= ref_meta_q;
         ref_prev_q <= ref_sync_q;
      end
   end

   assign ref_tick = ref_sync_q & ~ref_prev_q;   // one clk cycle wide

   timer_wb_regs u_regs (
      .clk_i     (clk_i),
      .rst_ni    (rst_ni),
      .wb_req_i  (wb_req_i),
      .wb_rsp_o  (wb_rsp_o),
      .cmd_lo_o  (cmd_lo),
      .cmd_hi_o  (cmd_hi),
      .stat_lo_i (stat_lo),
      .stat_hi_i (stat_hi)
   );

   timer_channel chan_lo (
      .clk_i      (clk_i),
      .rst_ni     (rst_ni),
      .cmd_i      (cmd_lo),
      .ref_tick_i (ref_tick),
      .stat_o     (stat_lo),
      .irq_o      (irq_lo_o),
      .busy_o     (busy_lo)
   );

   timer_channel chan_hi (
      .clk_i      (clk_i),
      .rst_ni     (rst_ni),
      .cmd_i      (cmd_hi),
      .ref_tick_i (ref_tick),
      .stat_o     (stat_hi),
      .irq_o      (irq_hi_o),
      .busy_o     (busy_hi)
   );

   assign busy_o = busy_lo | busy_hi;

endmodule

`default_nettype wire

/* test/timer_wb_master.sv */
// Testbench Wishbone master
`default_nettype none

module timer_wb_master (
   input  wire logic                     clk_i,
   output timer_bus_pkg::wb_req_t        wb_req_o,
   input  wire timer_bus_pkg::wb_rsp_t   wb_rsp_i
);
   timeunit 1ns;
   timeprecision 1ps;

   initial
      wb_req_o = '0;   // bus idle

   // one classic cycle, ack and read data sampled on the falling edge
   task automatic transfer(input logic we, input timer_bus_pkg::wb_addr_t adr,
                           input timer_bus_pkg::wb_data_t wdata,
                           output timer_bus_pkg::wb_data_t rdata);
      @(posedge clk_i);
      wb_req_o <= '{cyc: 1'b1, stb: 1'b1, we: we, sel: '1, adr: adr, dat: wdata};
      do
         @(negedge clk_i);
      while (!wb_rsp_i.ack);
      rdata = wb_rsp_i.dat;
      @(posedge clk_i);
      wb_req_o <= '0;   // drop stb and cyc after ack
   endtask

   task automatic write_word(input timer_bus_pkg::wb_addr_t adr,
                             input timer_bus_pkg::wb_data_t wdata);
      timer_bus_pkg::wb_data_t unused;
      transfer(1'b1, adr, wdata, unused);
   endtask

   task automatic read_word(input timer_bus_pkg::wb_addr_t adr,
                            output timer_bus_pkg::wb_data_t rdata);
      transfer(1'b0, adr, '0, rdata);
   endtask

endmodule

`default_nettype wire

/* test/tb_timer_unit.sv */
// Timer unit testbench
`default_nettype none

module tb_timer_unit;
   timeunit 1ns;
   timeprecision 1ps;

   logic clk;
   logic rst_ni;
   logic ref_clk;
   logic irq_lo;
   logic irq_hi;
   logic busy;
   timer_bus_pkg::wb_req_t wb_req;
   timer_bus_pkg::wb_rsp_t wb_rsp;

   byte         op_q[$];    // one entry per pattern line
   logic [31:0] off_q[$];
   logic [31:0] dat_q[$];
   logic [31:0] exp_q[$];
   int unsigned irq_cnt[2];
   int unsigned irq_seen[2];
   int unsigned cycles;
   int unsigned cycle_limit;
   int unsigned checks;
   int unsigned ref_half;    // ref_clk half period in clk cycles

   timer_unit DUT (
      .clk_i     (clk),
      .rst_ni    (rst_ni),
      .ref_clk_i (ref_clk),
      .wb_req_i  (wb_req),
      .wb_rsp_o  (wb_rsp),
      .irq_lo_o  (irq_lo),
      .irq_hi_o  (irq_hi),
      .busy_o    (busy)
   );

   timer_wb_master u_master (
      .clk_i    (clk),
      .wb_req_o (wb_req),
      .wb_rsp_i (wb_rsp)
   );

   always #50 clk = ~clk;

   // ************************************************************************
   // ref clock, irq monitor and watchdog
   // ************************************************************************
   initial
   begin
      wait (ref_half != 0);
      forever
      begin
         repeat (ref_half) @(posedge clk);
         ref_clk <= ~ref_clk;
      end
   end

   always @(negedge clk)
   begin
      if (irq_lo)
         irq_cnt[0]++;
      if (irq_hi)
         irq_cnt[1]++;
   end

   always @(posedge clk)
   begin
      cycles <= cycles + 1;
      if (cycles >= cycle_limit)
         fail_run($sformatf("timeout: the run hung and did not end within %0d cycles",
                            cycle_limit));
   end

   task automatic fail_run(input string msg);
      $display("%s", msg);
      $display("=== FAIL ===");
      $fatal(1, "stopped at first error");
   endtask

   task automatic check_result(input bit ok, input string what,
                               input logic [31:0] got, input logic [31:0] expected);
      checks++;
      assert (ok)
      else
         fail_run($sformatf("ERROR @ %0t: %s got %h, expected %h", $time, what, got,
                            expected));
   endtask

   // ************************************************************************
   // pattern load and run
   // ************************************************************************
   initial
   begin
      int          fd;
      string       line;
      byte         op;
      logic [31:0] off;
      logic [31:0] dat;
      logic [31:0] exp_v;
      logic [31:0] rdata;
      int unsigned got;

      void'($urandom(73));
      clk         = 1'b0;
      rst_ni      = 1'b0;
      ref_clk     = 1'b0;
      cycles      = 0;
      checks      = 0;
      cycle_limit = 200;
      fd = $fopen("test/timer_patterns.txt", "r");
      if (fd == 0)
         fail_run("could not open the pattern file test/timer_patterns.txt");
      else
      begin
         while ($fgets(line, fd))
         begin
            if (line.len() > 1 && line[0] != "#")
            begin
               void'($sscanf(line, "%c %h %h %h", op, off, dat, exp_v));
               op_q.push_back(op);
               off_q.push_back(off);
               dat_q.push_back(dat);
               exp_q.push_back(exp_v);
               if (op == "T")
                  cycle_limit += 2 * dat;
               else if (op == "W" || op == "R")
                  cycle_limit += 10;
            end
         end
         $fclose(fd);
      end
      ref_half = $urandom_range(8, 4);
      repeat (4) @(posedge clk);
      rst_ni <= 1'b1;

      foreach (op_q[i])
      begin
         if (op_q[i] == "W" || op_q[i] == "R")
            repeat ($urandom_range(3, 0)) @(posedge clk);   // idle gap
         case (op_q[i])
            "W": u_master.write_word(off_q[i][5:0], dat_q[i]);
            "R":
            begin
               u_master.read_word(off_q[i][5:0], rdata);
               if (dat_q[i] == 0)
                  check_result(rdata == exp_q[i],
                               $sformatf("read of offset %h", off_q[i]), rdata, exp_q[i]);
               else
                  check_result(rdata <= exp_q[i],
                               $sformatf("bounded read of offset %h", off_q[i]), rdata,
                               exp_q[i]);
            end
            "T": repeat (dat_q[i]) @(posedge clk);
            "I":
            begin
               @(posedge clk);   // monitor counts on the falling edge
               got = irq_cnt[off_q[i][0]] - irq_seen[off_q[i][0]];
               irq_seen[off_q[i][0]] = irq_cnt[off_q[i][0]];
               check_result(got == exp_q[i], $sformatf("irq count on channel %0d", off_q[i][0]),
                            got, exp_q[i]);
            end
            "B":
            begin
               @(negedge clk);
               check_result(busy == exp_q[i][0], "busy level", busy, exp_q[i]);
            end
            default: fail_run($sformatf("the pattern file holds an unknown opcode %c", op_q[i]));
         endcase
      end

      if (checks > 0)
      begin
         $display("=== PASS ===");
         $finish;
      end
      else
         fail_run("no checks were run because the pattern file held no results");
   end

endmodule

`default_nettype wire

/* timer_unit.f */
+incdir+source
source/timer_bus_pkg.sv
source/timer_cfg_pkg.sv
source/timer_wb_regs.sv
source/timer_channel.sv
source/timer_unit.sv
test/timer_wb_master.sv
test/tb_timer_unit.sv

/* Bender.yml */
package:
  name: timer_unit

sources:
  - include_dirs:
      - source
    files:
      - source/timer_bus_pkg.sv
      - source/timer_cfg_pkg.sv
      - source/timer_wb_regs.sv
      - source/timer_channel.sv
      - source/timer_unit.sv
  - target: test
    files:
      - test/timer_wb_master.sv
      - test/tb_timer_unit.sv

/* test/timer_patterns.txt */
# op offset data expected, all hex; R data 0 = equal, 1 = at most expected
# T waits data cycles; I offset 0 lo / 1 hi irq pulses since last I; B busy level
W 00 00005A74 0
R 00 0 00005A74
W 04 12340F26 0
R 04 0 12340F24
W 10 DEADBEEF 0
R 10 0 DEADBEEF
W 0C 00000055 0
R 0C 0 00000055
R 1C 0 0
W 10 00000014 0
W 00 00000024 0
W 18 0 0
T 0 28 0
R 08 0 15
I 0 0 1
B 0 0 0
W 00 00000032 0
W 18 0 0
T 0 1E 0
R 08 0 0
I 0 0 0
W 14 00000008 0
W 04 00000366 0
W 1C 0 0
T 0 6 0
R 0C 1 4
T 0 3C 0
R 0C 0 9
I 1 0 1
W 00 000000A6 0
W 18 0 0
R 08 1 13
T 0 170 0
R 08 0 15
I 0 0 1
W 00 00000003 0
T 0 3C 0
W 20 0 0
T 0 14 0
R 08 1 1E
R 0C 0 9
B 0 0 1
